// File: verilog/brainwars_pkg.sv
package brainwars_pkg;

	////////////////////////////////////////////////////////////////////////////
	// sizes and timing
	////////////////////////////////////////////////////////////////////////////
	localparam int KEYPAD_WIDTH   = 4;  // rows and columns of the keypad
	localparam int SCAN_DIV       = 8;  // clocks per driven row
	localparam int FRAME_BYTES    = 16; // characters per frame
	localparam int LCD_EN_HIGH    = 4;  // enable high time per write
	localparam int LCD_EN_LOW     = 4;  // enable low time after a write
	localparam int LCD_RST_CYCLES = 16; // panel reset hold
	localparam int LINK_CREDITS   = 2;  // lcd byte buffer depth

	localparam int CREDIT_W  = $clog2(LINK_CREDITS + 1);     // holds 0..LINK_CREDITS
	localparam int BUF_PTR_W = $clog2(LINK_CREDITS);         // buffer slot index
	localparam logic [CREDIT_W-1:0] CREDIT_INIT = CREDIT_W'(LINK_CREDITS); // credits at reset

	typedef enum logic [1:0] {SCR_IDLE, SCR_INVITE, SCR_GAME, SCR_RESULT} screen_t;

	typedef enum logic [7:0] {
		CMD_DISPLAY_ON = 8'h3f, // panel on
		CMD_SET_PAGE   = 8'hb8, // page 0
		CMD_SET_COL    = 8'h40  // column 0
	} lcd_cmd_t;

	typedef enum logic [1:0] {DIR_UP, DIR_LEFT, DIR_RIGHT, DIR_DOWN} dir_t;

	// key code is row*4 + column
	localparam logic [3:0] KEY_UP    = 4'd1;
	localparam logic [3:0] KEY_LEFT  = 4'd4;
	localparam logic [3:0] KEY_RIGHT = 4'd6;
	localparam logic [3:0] KEY_DOWN  = 4'd9;
	localparam logic [7:0] ARROW_BASE = 8'h80; // glyph for DIR_UP, others follow

	////////////////////////////////////////////////////////////////////////////
	// frame texts, byte 0 in the top bits
	////////////////////////////////////////////////////////////////////////////
	localparam logic [127:0] TXT_IDLE   = "BRAIN WARS      ";
	localparam logic [127:0] TXT_INVITE = "WAITING PLAYER  ";
	localparam logic [127:0] TXT_RESULT = "SCORE           "; // digits go in bytes 14, 15

	// score 0..99 as two ascii digits, tens first
	function automatic logic [15:0] score_digits(input logic [6:0] score);
		logic [6:0] tens;
		logic [6:0] ones;
		tens = score / 7'd10;
		ones = score % 7'd10;
		return {8'h30 + {1'b0, tens}, 8'h30 + {1'b0, ones}};
	endfunction

endpackage

// File: verilog/lcd_byte_if.sv
`timescale 1ns/1ps

// byte link from serializer to lcd controller, credit flow
interface lcd_byte_if;
	logic       valid;  // one byte this cycle, costs a credit
	logic [7:0] data;   // character byte
	logic       last;   // byte 15 of a frame
	logic       credit; // one buffer slot freed

	modport sender (
		output valid,
		output data,
		output last,
		input  credit
	);

	modport receiver (
		input  valid,
		input  data,
		input  last,
		output credit
	);
endinterface

// File: verilog/keypad_scan.sv
`timescale 1ns/1ps

module keypad_scan (
	input  logic                                   clk,     // system clock
	input  logic                                   rst_n,   // sync reset, active low
	input  logic [brainwars_pkg::KEYPAD_WIDTH-1:0] col_n,   // column sense, low = pressed
	output logic [brainwars_pkg::KEYPAD_WIDTH-1:0] row_n,   // one row driven low at a time
	output logic [3:0]                             key,     // row*4 + column
	output logic                                   pressed  // one pulse per new press
);

	logic [$clog2(brainwars_pkg::SCAN_DIV)-1:0] div_cnt; // clocks into current row slot
	logic [1:0] row_idx; // row being driven
	logic [1:0] col_idx; // lowest pulled-down column
	logic       sample;  // last clock of the slot, lines settled
	logic       hit;     // any column low
	logic       seen;    // key seen in an earlier row of this scan
	logic       held;    // repeat blocker

	assign sample = int'(div_cnt) == brainwars_pkg::SCAN_DIV - 1;
	assign hit    = col_n != '1;

	always_comb begin
		row_n          = '1;
		row_n[row_idx] = 1'b0; // active low drive
	end

	// lowest column wins when several are low
	always_comb begin
		col_idx = 2'd0;
		for (int i = brainwars_pkg::KEYPAD_WIDTH - 1; i >= 0; i--) begin
			if (!col_n[i]) begin
				col_idx = i[1:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			div_cnt <= '0;
			row_idx <= '0;
			seen    <= 1'b0;
			held    <= 1'b0;
			pressed <= 1'b0;
		end else begin
			pressed <= 1'b0;
			if (sample) begin
				div_cnt <= '0;
				row_idx <= row_idx + 2'd1; // next row, wraps after row 3
				if (hit && !held) begin
					pressed <= 1'b1;
					held    <= 1'b1;
				end
				if (int'(row_idx) == brainwars_pkg::KEYPAD_WIDTH - 1) begin
					seen <= 1'b0; // scan complete
					if (!seen && !hit) begin
						held <= 1'b0; // clear scan re-arms
					end
				end else begin
					seen <= seen | hit;
				end
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sample && hit && !held) begin
			key <= {row_idx, col_idx}; // captured with the pulse
		end
	end

endmodule

// File: verilog/flick_game.sv
`timescale 1ns/1ps

module flick_game (
	input  logic                   clk,        // system clock
	input  logic                   rst_n,      // sync reset, active low
	input  brainwars_pkg::screen_t screen,     // current board screen
	input  logic [3:0]             key,        // pressed key code
	input  logic                   pressed,    // new press pulse
	output logic                   point,      // one pulse per correct press
	output logic [6:0]             score,      // 0..99
	output logic [127:0]           game_frame  // arrow, spaces, score
);

	brainwars_pkg::dir_t target; // arrow on screen
	logic [3:0]  target_key;     // key that scores on this target
	logic [15:0] digits;         // score as ascii
	logic        hit;            // press matches target

	always_comb begin
		case (target)
			brainwars_pkg::DIR_UP:    target_key = brainwars_pkg::KEY_UP;
			brainwars_pkg::DIR_LEFT:  target_key = brainwars_pkg::KEY_LEFT;
			brainwars_pkg::DIR_RIGHT: target_key = brainwars_pkg::KEY_RIGHT;
			default:                  target_key = brainwars_pkg::KEY_DOWN;
		endcase
	end

	assign hit    = key == target_key;
	assign digits = brainwars_pkg::score_digits(score);

	// byte 0 glyph, bytes 1..13 blank, bytes 14..15 score
	assign game_frame = {
		brainwars_pkg::ARROW_BASE + {6'd0, target},
		{(brainwars_pkg::FRAME_BYTES - 3){8'h20}},
		digits
	};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			target <= brainwars_pkg::DIR_UP;
			score  <= '0;
			point  <= 1'b0;
		end else begin
			point <= 1'b0;
			if (screen == brainwars_pkg::SCR_IDLE) begin
				target <= brainwars_pkg::DIR_UP; // fresh round
				score  <= '0;
			end else if (screen == brainwars_pkg::SCR_GAME && pressed) begin
				// every press moves on, even a wrong or non-arrow key
				target <= brainwars_pkg::dir_t'(target + 2'd1);
				if (hit) begin
					point <= 1'b1;
					score <= (score == 7'd99) ? 7'd0 : score + 7'd1; // wraps at 99
				end
			end
		end
	end

endmodule

// File: verilog/display_ctl.sv
`timescale 1ns/1ps

module display_ctl (
	input  brainwars_pkg::screen_t screen,     // current board screen
	input  logic [6:0]             score,      // from the game
	input  logic [127:0]           game_frame, // game screen contents
	output logic [127:0]           frame       // chosen frame, byte 0 on top
);

	logic [127:0] result_frame; // score text with digits

	assign result_frame = {
		brainwars_pkg::TXT_RESULT[127:16],
		brainwars_pkg::score_digits(score)
	};

	always_comb begin
		case (screen)
			brainwars_pkg::SCR_IDLE:   frame = brainwars_pkg::TXT_IDLE;
			brainwars_pkg::SCR_INVITE: frame = brainwars_pkg::TXT_INVITE;
			brainwars_pkg::SCR_GAME:   frame = game_frame;
			default:                   frame = result_frame;
		endcase
	end

endmodule

// File: verilog/frame_serializer.sv
`timescale 1ns/1ps

module frame_serializer (
	input  logic         clk,   // system clock
	input  logic         rst_n, // sync reset, active low
	input  logic [127:0] frame, // frame from the screen selector
	lcd_byte_if.sender   link   // byte link to the lcd controller
);

	typedef enum logic {SER_LATCH, SER_SEND} ser_state_t;

	ser_state_t   state;
	logic [127:0] frame_q; // shifts left, next byte on top
	logic [$clog2(brainwars_pkg::FRAME_BYTES)-1:0] idx; // byte being sent
	logic [brainwars_pkg::CREDIT_W-1:0] credits; // free slots at the far end
	logic         send;      // byte goes out next cycle
	logic         last_byte; // idx at byte 15

	assign send      = (state == SER_SEND) && (credits != '0);
	assign last_byte = int'(idx) == brainwars_pkg::FRAME_BYTES - 1;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= SER_LATCH;
			idx        <= '0;
			credits    <= brainwars_pkg::CREDIT_INIT;
			link.valid <= 1'b0;
		end else begin
			link.valid <= send;
			case ({send, link.credit})
				2'b10:   credits <= credits - 1'b1; // spent
				2'b01:   credits <= credits + 1'b1; // returned
				default: credits <= credits;        // none or both
			endcase
			if (state == SER_LATCH) begin
				state <= SER_SEND;
				idx   <= '0;
			end else if (send) begin
				idx <= idx + 1'b1;
				if (last_byte) begin
					state <= SER_LATCH; // grab the next frame
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == SER_LATCH) begin
			frame_q <= frame;
		end else if (send) begin
			frame_q <= {frame_q[119:0], 8'h00};
		end
		if (send) begin
			link.data <= frame_q[127:120];
			link.last <= last_byte;
		end
	end

endmodule

// File: verilog/lcd_ctrl.sv
`timescale 1ns/1ps

module lcd_ctrl (
	input  logic         clk,      // system clock
	input  logic         rst_n,    // sync reset, active low
	input  logic         lcd_busy, // panel not ready for a new write
	lcd_byte_if.receiver link,     // bytes from the serializer
	output logic         lcd_rst,  // panel reset, active low
	output logic         lcd_en,   // write strobe
	output logic         lcd_di,   // 0 command, 1 data
	output logic [7:0]   lcd_data  // panel data bus
);

	typedef enum logic [2:0] {
		ST_RST_HOLD, // panel held in reset
		ST_INIT,     // power-up commands
		ST_COL,      // column command ahead of a frame
		ST_DATA,     // character writes
		ST_EN_HIGH,  // strobe high
		ST_EN_LOW    // strobe low recovery
	} state_t;

	state_t     state;
	logic [$clog2(brainwars_pkg::LCD_RST_CYCLES)-1:0] timer; // reset and strobe timing
	logic [1:0] init_idx;  // init commands issued so far
	logic       new_frame; // next byte opens a frame
	logic [7:0] init_cmd;  // command for init_idx
	logic       start_init;
	logic       start_col;
	logic       pop;       // byte leaves the buffer for the panel

	logic [7:0] fifo_data [brainwars_pkg::LINK_CREDITS];
	logic       fifo_last [brainwars_pkg::LINK_CREDITS];
	logic [brainwars_pkg::BUF_PTR_W-1:0] wr_ptr;
	logic [brainwars_pkg::BUF_PTR_W-1:0] rd_ptr;
	logic [brainwars_pkg::CREDIT_W-1:0]  count; // bytes held

	function automatic logic [brainwars_pkg::BUF_PTR_W-1:0] ptr_next(
		input logic [brainwars_pkg::BUF_PTR_W-1:0] ptr
	);
		if (int'(ptr) == brainwars_pkg::LINK_CREDITS - 1) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	always_comb begin
		case (init_idx)
			2'd0:    init_cmd = brainwars_pkg::CMD_DISPLAY_ON;
			2'd1:    init_cmd = brainwars_pkg::CMD_SET_PAGE;
			default: init_cmd = brainwars_pkg::CMD_SET_COL;
		endcase
	end

	// a busy panel only holds off the start of a write
	assign start_init = (state == ST_INIT) && !lcd_busy;
	assign start_col  = (state == ST_COL) && !lcd_busy;
	assign pop        = (state == ST_DATA) && (count != '0) && !new_frame && !lcd_busy;

	////////////////////////////////////////////////////////////////////////////
	// write sequencer
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= ST_RST_HOLD;
			timer     <= '0;
			init_idx  <= '0;
			new_frame <= 1'b1; // first byte ever opens a frame
			lcd_rst   <= 1'b0;
			lcd_en    <= 1'b0;
		end else begin
			case (state)
				ST_RST_HOLD: begin
					if (int'(timer) == brainwars_pkg::LCD_RST_CYCLES - 1) begin
						timer   <= '0;
						lcd_rst <= 1'b1;
						state   <= ST_INIT;
					end else begin
						timer <= timer + 1'b1;
					end
				end
				ST_INIT: begin
					if (start_init) begin
						init_idx <= init_idx + 2'd1;
						lcd_en   <= 1'b1;
						state    <= ST_EN_HIGH;
					end
				end
				ST_COL: begin
					if (start_col) begin
						new_frame <= 1'b0;
						lcd_en    <= 1'b1;
						state     <= ST_EN_HIGH;
					end
				end
				ST_DATA: begin
					if (pop) begin
						new_frame <= fifo_last[rd_ptr]; // frame ends after this byte
						lcd_en    <= 1'b1;
						state     <= ST_EN_HIGH;
					end else if (count != '0 && new_frame) begin
						state <= ST_COL;
					end
				end
				ST_EN_HIGH: begin
					if (int'(timer) == brainwars_pkg::LCD_EN_HIGH - 1) begin
						timer  <= '0;
						lcd_en <= 1'b0; // panel latches on this fall
						state  <= ST_EN_LOW;
					end else begin
						timer <= timer + 1'b1;
					end
				end
				ST_EN_LOW: begin
					if (int'(timer) == brainwars_pkg::LCD_EN_LOW - 1) begin
						timer <= '0;
						state <= (init_idx == 2'd3) ? ST_DATA : ST_INIT; // three init cmds
					end else begin
						timer <= timer + 1'b1;
					end
				end
				default: state <= ST_RST_HOLD;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// byte buffer and credit return
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			link.credit <= 1'b0;
		end else begin
			link.credit <= pop; // one credit per byte taken
			if (link.valid) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({link.valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (link.valid) begin
			fifo_data[wr_ptr] <= link.data;
			fifo_last[wr_ptr] <= link.last;
		end
		// bus stays put for the whole strobe
		if (start_init) begin
			lcd_data <= init_cmd;
			lcd_di   <= 1'b0;
		end else if (start_col) begin
			lcd_data <= brainwars_pkg::CMD_SET_COL;
			lcd_di   <= 1'b0;
		end else if (pop) begin
			lcd_data <= fifo_data[rd_ptr];
			lcd_di   <= 1'b1;
		end
	end

endmodule

// File: verilog/brainwars_main.sv
`timescale 1ns/1ps

module brainwars_main (
	input  logic                   clk,      // system clock
	input  logic                   rst_n,    // sync reset, active low
	input  brainwars_pkg::screen_t screen,   // screen code from the board fsm
	input  logic [3:0]             col_n,    // keypad columns
	output logic [3:0]             row_n,    // keypad rows
	input  logic                   lcd_busy, // panel busy
	output logic                   lcd_rst,  // panel reset
	output logic                   lcd_en,   // panel strobe
	output logic                   lcd_di,   // panel data/instruction
	output logic [7:0]             lcd_data, // panel data bus
	output logic                   point     // correct press pulse
);

	logic [3:0]   key;        // decoded key
	logic         pressed;    // new press
	logic [6:0]   score;      // game score
	logic [127:0] game_frame; // game screen
	logic [127:0] frame;      // selected screen

	lcd_byte_if link ();

	keypad_scan u_keypad_scan (
		.clk     (clk),
		.rst_n   (rst_n),
		.col_n   (col_n),
		.row_n   (row_n),
		.key     (key),
		.pressed (pressed)
	);

	flick_game u_flick_game (
		.clk        (clk),
		.rst_n      (rst_n),
		.screen     (screen),
		.key        (key),
		.pressed    (pressed),
		.point      (point),
		.score      (score),
		.game_frame (game_frame)
	);

	display_ctl u_display_ctl (
		.screen     (screen),
		.score      (score),
		.game_frame (game_frame),
		.frame      (frame)
	);

	frame_serializer u_frame_serializer (
		.clk   (clk),
		.rst_n (rst_n),
		.frame (frame),
		.link  (link)
	);

	lcd_ctrl u_lcd_ctrl (
		.clk      (clk),
		.rst_n    (rst_n),
		.lcd_busy (lcd_busy),
		.link     (link),
		.lcd_rst  (lcd_rst),
		.lcd_en   (lcd_en),
		.lcd_di   (lcd_di),
		.lcd_data (lcd_data)
	);

endmodule

// File: bench/keypad_model.sv
`timescale 1ns/1ps

// 4x4 key matrix, one key at a time
module keypad_model (
	input  logic [3:0] row_n,    // row drive from the scanner, low = driven
	input  logic [3:0] key,      // row*4 + column of the held key
	input  logic       key_down, // key is held
	output logic [3:0] col_n     // column sense, pulled up when open
);

	logic [1:0] key_row; // row of the held key
	logic [1:0] key_col; // column of the held key

	assign key_row = key[3:2];
	assign key_col = key[1:0];

	always_comb begin
		col_n = 4'b1111; // pull-ups
		if (key_down && !row_n[key_row]) begin
			col_n[key_col] = 1'b0; // switch shorts the row to the column
		end
	end

endmodule

// File: bench/brainwars_tb.sv
`timescale 1ns/1ps

module brainwars_tb;

	localparam int SCAN_CLKS     = brainwars_pkg::KEYPAD_WIDTH * brainwars_pkg::SCAN_DIV;
	localparam int PRESS_TIMEOUT = 3 * SCAN_CLKS; // detection within two scans
	localparam int REARM_TIMEOUT = 3 * SCAN_CLKS;
	localparam int FRAME_TIMEOUT = 2000;          // clocks per awaited frame
	localparam int HOLD_SCANS    = 6;             // long press length

	typedef struct packed {
		brainwars_pkg::screen_t scr;
		logic                   has_key;
		logic [3:0]             key;
		logic                   long_hold;
		logic                   exp_point;
		int                     exp_score;
		logic [127:0]           exp_frame;
	} step_t;

	logic                   clk      = 1'b0;
	logic                   rst_n    = 1'b0;
	brainwars_pkg::screen_t screen   = brainwars_pkg::SCR_IDLE;
	logic [3:0]             key_code = 4'd0;
	logic                   key_down = 1'b0;
	logic                   lcd_busy = 1'b0;
	logic [3:0]             col_n;
	logic [3:0]             row_n;
	logic                   lcd_rst;
	logic                   lcd_en;
	logic                   lcd_di;
	logic [7:0]             lcd_data;
	logic                   point;

	logic [31:0]  lfsr = 32'hae73; // stall generator
	logic         stall_bit;
	logic         prev_en     = 1'b0;
	int           en_len      = 0;   // negedges seen with lcd_en high
	logic [8:0]   held_write  = '0;  // di and data at the strobe rise
	int           n_writes    = 0;
	logic         in_frame    = 1'b0;
	int           byte_idx    = 0;
	logic         frame_done  = 1'b0;
	logic [127:0] cap_buf     = '0;
	logic [127:0] last_frame  = '0;  // newest complete frame
	int           frame_count = 0;
	int           m_target    = 0;   // model of the on-screen arrow
	int           m_score     = 0;   // model of the score
	step_t        steps [0:15];
	int           n_steps     = 0;

	brainwars_main u_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.screen   (screen),
		.col_n    (col_n),
		.row_n    (row_n),
		.lcd_busy (lcd_busy),
		.lcd_rst  (lcd_rst),
		.lcd_en   (lcd_en),
		.lcd_di   (lcd_di),
		.lcd_data (lcd_data),
		.point    (point)
	);

	keypad_model u_keypad (
		.row_n    (row_n),
		.key      (key_code),
		.key_down (key_down),
		.col_n    (col_n)
	);

	always #2 clk = ~clk; // 4 ns period

	////////////////////////////////////////////////////////////////////////////
	// model helpers
	////////////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
	endfunction

	function automatic logic [3:0] arrow_key(input int dir);
		case (dir)
			0:       return brainwars_pkg::KEY_UP;
			1:       return brainwars_pkg::KEY_LEFT;
			2:       return brainwars_pkg::KEY_RIGHT;
			default: return brainwars_pkg::KEY_DOWN;
		endcase
	endfunction

	function automatic logic [15:0] score_ascii(input int sc);
		logic [7:0] tens;
		logic [7:0] ones;
		tens = 8'h30 + 8'(sc / 10);
		ones = 8'h30 + 8'(sc % 10);
		return {tens, ones};
	endfunction

	function automatic logic [127:0] model_frame(input brainwars_pkg::screen_t scr,
		input int tgt, input int sc);
		logic [39:0] score_txt;
		score_txt = "SCORE";
		case (scr)
			brainwars_pkg::SCR_IDLE:   return "BRAIN WARS      ";
			brainwars_pkg::SCR_INVITE: return "WAITING PLAYER  ";
			brainwars_pkg::SCR_GAME:
				return {brainwars_pkg::ARROW_BASE + 8'(tgt), {13{8'h20}}, score_ascii(sc)};
			default:                   return {score_txt, {9{8'h20}}, score_ascii(sc)};
		endcase
	endfunction

	function automatic logic [7:0] init_cmd(input int n);
		case (n)
			0:       return brainwars_pkg::CMD_DISPLAY_ON;
			1:       return brainwars_pkg::CMD_SET_PAGE;
			default: return brainwars_pkg::CMD_SET_COL;
		endcase
	endfunction

	task automatic fail_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		$display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic fail_other(input string what);
		$display("Error at %0t ns: %s", $time, what);
		$display("Some tests failed");
		$fatal(1);
	endtask

	// runs the target and score rules and stores one table row
	task automatic add_step(input brainwars_pkg::screen_t scr, input logic has_key,
		input logic [3:0] k, input logic long_hold);
		step_t s;
		s.scr       = scr;
		s.has_key   = has_key;
		s.key       = k;
		s.long_hold = long_hold;
		s.exp_point = 1'b0;
		if (scr == brainwars_pkg::SCR_IDLE) begin
			m_target = 0; // round restarts
			m_score  = 0;
		end else if (scr == brainwars_pkg::SCR_GAME && has_key) begin
			if (k == arrow_key(m_target)) begin
				s.exp_point = 1'b1;
				m_score     = (m_score == 99) ? 0 : m_score + 1;
			end
			m_target = (m_target + 1) % 4; // any press moves on
		end
		s.exp_score    = m_score;
		s.exp_frame    = model_frame(scr, m_target, m_score);
		steps[n_steps] = s;
		n_steps++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// busy stalls and lcd capture
	////////////////////////////////////////////////////////////////////////////
	always @(negedge clk) begin
		lfsr      = lfsr_step(lfsr);
		stall_bit = lfsr[0];
		lfsr      = lfsr_step(lfsr);
		lcd_busy  = stall_bit & lfsr[0]; // busy about one clock in four
	end

	task record_write(input logic di, input logic [7:0] data);
		if (n_writes < 3) begin
			assert (!di && data == init_cmd(n_writes))
				else fail_value("init lcd_di lcd_data", {di, data}, {1'b0, init_cmd(n_writes)});
		end else if (!di) begin
			assert (data == brainwars_pkg::CMD_SET_COL)
				else fail_value("lcd_data", data, brainwars_pkg::CMD_SET_COL);
			assert (!in_frame) else fail_other("column command came before 16 data bytes");
			in_frame = 1'b1;
			byte_idx = 0;
		end else begin
			assert (in_frame) else fail_other("data byte came without a column command");
			cap_buf[8 * (15 - byte_idx) +: 8] = data; // byte 0 on top
			byte_idx++;
			if (byte_idx == brainwars_pkg::FRAME_BYTES) begin
				in_frame   = 1'b0;
				frame_done = 1'b1;
			end
		end
		n_writes++;
	endtask

	always @(negedge clk) begin
		frame_done = 1'b0;
		if (lcd_rst) begin
			if (lcd_en && !prev_en) begin
				record_write(lcd_di, lcd_data); // strobe rise
				held_write = {lcd_di, lcd_data};
				en_len     = 1;
			end else if (lcd_en) begin
				en_len++;
				assert ({lcd_di, lcd_data} == held_write)
					else fail_value("lcd_di lcd_data", {lcd_di, lcd_data}, held_write);
			end else if (prev_en) begin
				assert (en_len == brainwars_pkg::LCD_EN_HIGH)
					else fail_value("lcd_en high clocks", en_len, brainwars_pkg::LCD_EN_HIGH);
			end
			prev_en = lcd_en;
		end
		if (frame_done) begin
			last_frame  <= cap_buf;
			frame_count <= frame_count + 1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////
	task automatic reset_and_check();
		int cnt;
		rst_n = 1'b0;
		repeat (4) @(negedge clk);
		assert (row_n == 4'b1110) else fail_value("row_n", row_n, 4'b1110);
		assert (!lcd_rst) else fail_value("lcd_rst", lcd_rst, 1'b0);
		rst_n = 1'b1;
		cnt   = 0;
		while (!lcd_rst && cnt < 4 * brainwars_pkg::LCD_RST_CYCLES) begin
			@(negedge clk);
			cnt++;
			assert (!lcd_en) else fail_value("lcd_en", lcd_en, 1'b0);
			assert (!point) else fail_value("point", point, 1'b0);
		end
		assert (lcd_rst) else fail_other("timeout waiting for lcd_rst to rise");
		assert (cnt == brainwars_pkg::LCD_RST_CYCLES)
			else fail_value("lcd_rst low clocks", cnt, brainwars_pkg::LCD_RST_CYCLES);
	endtask

	task automatic press_key(input step_t s);
		logic       found;
		int         extra;
		int         wraps;
		logic [3:0] prev_row;
		found    = 1'b0;
		key_code = s.key;
		key_down = 1'b1;
		for (int i = 0; i < PRESS_TIMEOUT && !found; i++) begin
			@(negedge clk);
			found = u_dut.pressed;
		end
		assert (found) else fail_other("timeout waiting for the keypad to report a press");
		assert (u_dut.key == s.key) else fail_value("key", u_dut.key, s.key);
		@(negedge clk); // point follows pressed by one clock
		assert (point == s.exp_point) else fail_value("point", point, s.exp_point);
		assert (u_dut.score == 7'(s.exp_score)) else fail_value("score", u_dut.score, s.exp_score);
		if (s.long_hold) begin
			extra = 0;
			repeat (HOLD_SCANS * SCAN_CLKS) begin
				@(negedge clk);
				if (u_dut.pressed) begin
					extra++;
				end
			end
			assert (extra == 0) else fail_value("extra pressed pulses", extra, 0);
		end
		key_down = 1'b0;
		wraps    = 0; // partial scan then one clean scan re-arms
		prev_row = row_n;
		for (int i = 0; i < REARM_TIMEOUT && wraps < 2; i++) begin
			@(negedge clk);
			if (prev_row == 4'b0111 && row_n == 4'b1110) begin
				wraps++;
			end
			prev_row = row_n;
		end
		assert (wraps == 2) else fail_other("keypad rows stopped rotating");
	endtask

	task automatic wait_frame_count(input int target);
		for (int i = 0; i < FRAME_TIMEOUT && frame_count < target; i++) begin
			@(negedge clk);
		end
		assert (frame_count >= target) else fail_other("timeout waiting for a complete frame");
	endtask

	// the next two frames may still hold older text
	task automatic check_frames(input int c0, input logic [127:0] exp);
		for (int n = 3; n <= 4; n++) begin
			wait_frame_count(c0 + n);
			assert (last_frame == exp) else fail_value("frame", last_frame, exp);
		end
	endtask

	initial begin
		int c0;
		add_step(brainwars_pkg::SCR_IDLE,   1'b0, 4'd0, 1'b0);
		add_step(brainwars_pkg::SCR_INVITE, 1'b0, 4'd0, 1'b0);
		add_step(brainwars_pkg::SCR_GAME,   1'b0, 4'd0, 1'b0);
		add_step(brainwars_pkg::SCR_GAME,   1'b1, brainwars_pkg::KEY_UP, 1'b0);
		add_step(brainwars_pkg::SCR_GAME,   1'b1, brainwars_pkg::KEY_RIGHT, 1'b0); // miss
		add_step(brainwars_pkg::SCR_GAME,   1'b1, brainwars_pkg::KEY_RIGHT, 1'b0);
		add_step(brainwars_pkg::SCR_GAME,   1'b1, 4'd0, 1'b0);                   // not an arrow
		add_step(brainwars_pkg::SCR_GAME,   1'b1, brainwars_pkg::KEY_UP, 1'b1);    // long hold
		add_step(brainwars_pkg::SCR_GAME,   1'b1, brainwars_pkg::KEY_LEFT, 1'b0);
		add_step(brainwars_pkg::SCR_GAME,   1'b1, brainwars_pkg::KEY_UP, 1'b0);    // miss
		add_step(brainwars_pkg::SCR_RESULT, 1'b0, 4'd0, 1'b0);
		add_step(brainwars_pkg::SCR_IDLE,   1'b0, 4'd0, 1'b0);
		add_step(brainwars_pkg::SCR_GAME,   1'b0, 4'd0, 1'b0);
		add_step(brainwars_pkg::SCR_GAME,   1'b1, brainwars_pkg::KEY_UP, 1'b0);
		reset_and_check();
		for (int i = 0; i < n_steps; i++) begin
			@(negedge clk);
			screen = steps[i].scr;
			if (steps[i].has_key) begin
				press_key(steps[i]);
			end
			c0 = frame_count;
			check_frames(c0, steps[i].exp_frame);
		end
		$display("All tests passed");
		$finish;
	end

endmodule

// File: brainwars.f
verilog/brainwars_pkg.sv
verilog/lcd_byte_if.sv
verilog/keypad_scan.sv
verilog/flick_game.sv
verilog/display_ctl.sv
verilog/frame_serializer.sv
verilog/lcd_ctrl.sv
verilog/brainwars_main.sv
bench/keypad_model.sv
bench/brainwars_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the brainwars testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module brainwars_tb --Mdir obj_dir -o brainwars_sim \
	-f brainwars.f

./obj_dir/brainwars_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
	echo "simulation PASSED"
else
	echo "simulation FAILED"
	exit 1
fi
